// ==== all.f ====
rtl/vec_pkg.sv
rtl/vec_rf_if.sv
rtl/vec_issue_if.sv
rtl/vec_decode.sv
rtl/vec_execute.sv
rtl/vec_result.sv
rtl/vec_unit_top.sv
verif/vec_unit_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the vector unit testbench with Verilator.
# Fails if the build or run fails, or if the log reports a failing test.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f all.f --top-module vec_unit_tb \
  -Mdir obj_dir -o vec_unit_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/vec_unit_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TEST FAIL" "$LOG"; then
  exit 1
fi
exit 0

// ==== verif/vec_unit_tb.sv ====
// testbench that checks random OP-V instructions on the two-lane vector unit
// covers host access, masking, illegal encodings, stall and flush
`default_nettype none

module vec_unit_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int VLMAX   = 8;
  localparam int TIMEOUT = 200;
  localparam logic [5:0] F6_SET [5] = '{vec_pkg::F6_VADD, vec_pkg::F6_VSUB,
    vec_pkg::F6_VAND, vec_pkg::F6_VOR, vec_pkg::F6_VXOR};

  logic           CLK;
  logic           nRST;
  logic           instr_valid;
  logic [31:0]    instr;
  vec_pkg::elem_t xs1;
  logic [5:0]     vl;
  logic           stall;
  logic           flush;
  logic           busy;
  logic           illegal;
  logic           done;
  logic           host_wen;
  logic [4:0]     host_reg;
  logic [4:0]     host_idx;
  vec_pkg::elem_t host_data;
  logic [4:0]     rd_reg;
  logic [4:0]     rd_idx;
  vec_pkg::elem_t rd_data;

  // register file as the testbench expects it
  vec_pkg::elem_t mirror [32][VLMAX];
  int checks;
  int errors;
  int timeouts;

  vec_unit_top #(.VLMAX(VLMAX)) UUT (
    .CLK(CLK), .nRST(nRST), .instr_valid(instr_valid), .instr(instr), .xs1(xs1),
    .vl(vl), .stall(stall), .flush(flush), .busy(busy), .illegal(illegal), .done(done),
    .host_wen(host_wen), .host_reg(host_reg), .host_idx(host_idx),
    .host_data(host_data), .rd_reg(rd_reg), .rd_idx(rd_idx), .rd_data(rd_data)
  );

  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("Error at %0t ns: %s expected %h, got %h", $time, name, exp, got);
    end
  endtask

  // vs2 element combined with the first operand
  function automatic vec_pkg::elem_t model_alu(input logic [5:0] f6,
                                               input vec_pkg::elem_t vs2_elem,
                                               input vec_pkg::elem_t opnd);
    case (f6)
      vec_pkg::F6_VSUB: return vs2_elem - opnd;
      vec_pkg::F6_VAND: return vs2_elem & opnd;
      vec_pkg::F6_VOR:  return vs2_elem | opnd;
      vec_pkg::F6_VXOR: return vs2_elem ^ opnd;
      default:          return vs2_elem + opnd;
    endcase
  endfunction

  task automatic load_registers();
    vec_pkg::elem_t v;
    for (int r = 0; r < 32; r++) begin
      for (int i = 0; i < VLMAX; i++) begin
        v = $urandom();
        @(posedge CLK);
        host_wen  <= 1'b1;
        host_reg  <= 5'(r);
        host_idx  <= 5'(i);
        host_data <= v;
        mirror[r][i] = v;
      end
    end
    @(posedge CLK);
    host_wen <= 1'b0;
  endtask

  task automatic read_elem(input logic [4:0] r, input int i, output vec_pkg::elem_t val);
    @(posedge CLK);
    rd_reg <= r;
    rd_idx <= 5'(i);
    @(negedge CLK);
    val = rd_data;
  endtask

  task automatic compare_reg(input logic [4:0] r);
    vec_pkg::elem_t got;
    for (int i = 0; i < VLMAX; i++) begin
      read_elem(r, i, got);
      check_val($sformatf("rd_data v%0d[%0d]", r, i), mirror[r][i], got);
    end
  endtask

  task automatic compare_all();
    for (int r = 0; r < 32; r++) begin
      compare_reg(5'(r));
    end
  endtask

  // drive one instruction and follow busy until it drops
  task automatic issue_and_wait(input logic [31:0] word, input vec_pkg::elem_t scal,
                                input int vlen, input bit rand_stall, input int flush_edge,
                                output int cyc, output int dones);
    bit running;
    cyc = 0;
    dones = 0;
    running = 1'b1;
    @(posedge CLK);
    instr_valid <= 1'b1;
    instr       <= word;
    xs1         <= scal;
    vl          <= 6'(vlen);
    @(posedge CLK);
    instr_valid <= 1'b0;
    do begin
      stall <= rand_stall && ($urandom_range(0, 2) == 0);
      flush <= (flush_edge == cyc + 1);
      @(negedge CLK);
      if (done) dones++;
      if (flush_edge != 0 && cyc == flush_edge) check_val("busy after flush", 32'd0, 32'(busy));
      running = busy;
      if (running) begin
        @(posedge CLK);
        cyc++;
      end
    end while (running && cyc < TIMEOUT);
    assert (!running) else begin
      timeouts++;
      $display("timeout, busy still high after %0d cycles", TIMEOUT);
    end
    @(posedge CLK);
    stall <= 1'b0;
    flush <= 1'b0;
  endtask

  task automatic exec_random(input logic vm, input bit rand_stall, input bit do_flush);
    logic [5:0]     f6;
    logic [2:0]     f3;
    logic [4:0]     vs1;
    logic [4:0]     vs2;
    logic [4:0]     vd;
    vec_pkg::elem_t scal;
    vec_pkg::elem_t opnd;
    vec_pkg::elem_t got;
    vec_pkg::elem_t expv [VLMAX];
    vec_pkg::elem_t mask;
    int vlen;
    int pairs;
    int flush_edge;
    int cyc;
    int dones;
    f6   = F6_SET[$urandom_range(0, 4)];
    f3   = ($urandom_range(0, 2) == 0) ? vec_pkg::F3_OPIVV :
           ($urandom_range(0, 1) == 0) ? vec_pkg::F3_OPIVX : vec_pkg::F3_OPIVI;
    // no vsub.vi in the ISA
    if (f6 == vec_pkg::F6_VSUB && f3 == vec_pkg::F3_OPIVI) f3 = vec_pkg::F3_OPIVX;
    vs1  = 5'($urandom_range(0, 31));
    vs2  = 5'($urandom_range(0, 31));
    vd   = 5'($urandom_range(0, 31));
    scal = $urandom();
    vlen = do_flush ? VLMAX : $urandom_range(1, VLMAX);
    pairs = (vlen + 1) / 2;
    flush_edge = do_flush ? $urandom_range(1, pairs) : 0;
    mask = mirror[0][0];
    for (int i = 0; i < VLMAX; i++) begin
      if (f3 == vec_pkg::F3_OPIVV) opnd = mirror[vs1][i];
      else if (f3 == vec_pkg::F3_OPIVX) opnd = scal;
      else opnd = {{27{vs1[4]}}, vs1};
      expv[i] = mirror[vd][i];
      if (i < vlen && (vm || mask[i])) expv[i] = model_alu(f6, mirror[vs2][i], opnd);
    end
    issue_and_wait({f6, vm, vs2, vs1, f3, vd, vec_pkg::OPC_OPV}, scal, vlen, rand_stall,
                   flush_edge, cyc, dones);
    check_val("done pulses", do_flush ? 32'd0 : 32'd1, 32'(dones));
    if (!rand_stall && !do_flush) check_val("busy cycles", 32'(pairs + 1), 32'(cyc));
    for (int i = 0; i < VLMAX; i++) begin
      read_elem(vd, i, got);
      if (do_flush) begin
        // a flushed pair may or may not have landed
        checks++;
        assert (got === mirror[vd][i] || got === expv[i]) else begin
          errors++;
          $display("Error at %0t ns: rd_data v%0d[%0d] is %h, neither old %h nor new %h",
                   $time, vd, i, got, mirror[vd][i], expv[i]);
        end
        mirror[vd][i] = got;
      end else begin
        check_val($sformatf("rd_data v%0d[%0d]", vd, i), expv[i], got);
        mirror[vd][i] = expv[i];
      end
    end
  endtask

  task automatic try_illegal(input logic [31:0] word);
    @(posedge CLK);
    instr_valid <= 1'b1;
    instr       <= word;
    xs1         <= $urandom();
    vl          <= 6'(VLMAX);
    @(posedge CLK);
    instr_valid <= 1'b0;
    @(negedge CLK);
    check_val("illegal", 32'd1, 32'(illegal));
    check_val("busy", 32'd0, 32'(busy));
    check_val("done", 32'd0, 32'(done));
    repeat (4) begin
      @(negedge CLK);
      check_val("illegal", 32'd0, 32'(illegal));
      check_val("busy", 32'd0, 32'(busy));
      check_val("done", 32'd0, 32'(done));
    end
  endtask

  initial begin
    checks = 0;
    errors = 0;
    timeouts = 0;
    nRST <= 1'b0;
    instr_valid <= 1'b0;
    instr <= '0;
    xs1 <= '0;
    vl <= '0;
    stall <= 1'b0;
    flush <= 1'b0;
    host_wen <= 1'b0;
    host_reg <= '0;
    host_idx <= '0;
    host_data <= '0;
    rd_reg <= '0;
    rd_idx <= '0;
    void'($urandom(32'hdc62_bea6));
    repeat (10) @(posedge CLK);
    nRST <= 1'b1;
    @(negedge CLK);
    check_val("busy", 32'd0, 32'(busy));
    check_val("illegal", 32'd0, 32'(illegal));
    check_val("done", 32'd0, 32'(done));

    load_registers();
    compare_all();
    repeat (30) exec_random(1'b1, 1'b0, 1'b0);
    // masked by v0
    repeat (20) exec_random(1'b0, 1'b0, 1'b0);
    try_illegal({vec_pkg::F6_VSUB, 1'b1, 5'd3, 5'd7, vec_pkg::F3_OPIVI, 5'd9, vec_pkg::OPC_OPV});
    try_illegal({6'b111111, 1'b1, 5'd4, 5'd5, vec_pkg::F3_OPIVV, 5'd6, vec_pkg::OPC_OPV});
    try_illegal({vec_pkg::F6_VADD, 1'b1, 5'd1, 5'd2, vec_pkg::F3_OPIVV, 5'd3, 7'b0110011});
    compare_all();
    repeat (20) exec_random(1'($urandom_range(0, 1)), 1'b1, 1'b0);
    repeat (4) begin
      exec_random(1'($urandom_range(0, 1)), 1'b0, 1'b1);
      exec_random(1'b1, 1'b0, 1'b0);
    end
    compare_all();

    $display("checks: %0d  errors: %0d  timeouts: %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== rtl/vec_unit_top.sv ====
// two-lane vector integer unit, decode, execute and result stages
// plain ports only, VLMAX is the element count per register
`default_nettype none

module vec_unit_top #(
  parameter int VLMAX = 8
) (
  input  logic           CLK,
  input  logic           nRST,
  input  logic           instr_valid,
  input  logic [31:0]    instr,
  input  vec_pkg::elem_t xs1,
  input  logic [5:0]     vl,
  input  logic           stall,
  input  logic           flush,
  output logic           busy,
  output logic           illegal,
  output logic           done,
  input  logic           host_wen,
  input  logic [4:0]     host_reg,
  input  logic [4:0]     host_idx,
  input  vec_pkg::elem_t host_data,
  input  logic [4:0]     rd_reg,
  input  logic [4:0]     rd_idx,
  output vec_pkg::elem_t rd_data
);

  vec_rf_if    rf_bus ();
  vec_issue_if iss_bus ();

  vec_decode #(.VLMAX(VLMAX)) u_decode (
    .CLK         (CLK),
    .nRST        (nRST),
    .instr_valid (instr_valid),
    .instr       (instr),
    .xs1         (xs1),
    .vl          (vl),
    .stall       (stall),
    .flush       (flush),
    .busy        (busy),
    .illegal     (illegal),
    .rf          (rf_bus.decode),
    .iss         (iss_bus.decode)
  );

  vec_execute u_execute (
    .CLK   (CLK),
    .nRST  (nRST),
    .stall (stall),
    .flush (flush),
    .iss   (iss_bus.execute)
  );

  vec_result #(.VLMAX(VLMAX)) u_result (
    .CLK       (CLK),
    .nRST      (nRST),
    .stall     (stall),
    .host_wen  (host_wen),
    .host_reg  (host_reg),
    .host_idx  (host_idx),
    .host_data (host_data),
    .rd_reg    (rd_reg),
    .rd_idx    (rd_idx),
    .rd_data   (rd_data),
    .done      (done),
    .rf        (rf_bus.regfile),
    .iss       (iss_bus.result)
  );

endmodule

`default_nettype wire

// ==== rtl/vec_result.sv ====
// vector register file with two lane write ports, the host ports and the done pulse
// also serves the decode reads and the v0 mask word
`default_nettype none

module vec_result #(
  parameter int VLMAX = 8
) (
  input  logic           CLK,
  input  logic           nRST,
  input  logic           stall,
  input  logic           host_wen,
  input  logic [4:0]     host_reg,
  input  logic [4:0]     host_idx,
  input  vec_pkg::elem_t host_data,
  input  logic [4:0]     rd_reg,
  input  logic [4:0]     rd_idx,
  output vec_pkg::elem_t rd_data,
  output logic           done,
  vec_rf_if.regfile      rf,
  vec_issue_if.result    iss
);

  localparam int IW = (VLMAX > 1) ? $clog2(VLMAX) : 1;

  vec_pkg::elem_t regs [vec_pkg::NREG][VLMAX];

  logic [IW-1:0] rd0;
  logic [IW-1:0] rd1;
  logic [IW-1:0] wr0;
  logic [IW-1:0] wr1;
  logic          lane_go;

  // lane 0 always sits on an even index, so lane 1 stays in range
  assign rd0 = rf.offset[IW-1:0];
  assign rd1 = rd0 + IW'(1);
  assign wr0 = iss.res_offset[IW-1:0];
  assign wr1 = wr0 + IW'(1);

  assign rf.vs1_data0 = regs[rf.vs1][rd0];
  assign rf.vs1_data1 = regs[rf.vs1][rd1];
  assign rf.vs2_data0 = regs[rf.vs2][rd0];
  assign rf.vs2_data1 = regs[rf.vs2][rd1];
  assign rf.mask_word = regs[0][0];

  // host read, outside the register reads as zero
  assign rd_data = (int'(rd_idx) < VLMAX) ? regs[rd_reg][rd_idx[IW-1:0]] : '0;

  assign lane_go = iss.res_valid && !stall;

  always_ff @(posedge CLK) begin
    if (lane_go && iss.res_wen0) begin
      regs[iss.res_vd][wr0] <= iss.res0;
    end
    if (lane_go && iss.res_wen1) begin
      regs[iss.res_vd][wr1] <= iss.res1;
    end
    // host only writes while the unit is idle
    if (host_wen && int'(host_idx) < VLMAX) begin
      regs[host_reg][host_idx[IW-1:0]] <= host_data;
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      done <= 1'b0;
    end else begin
      done <= lane_go && iss.res_last;
    end
  end

  a_lane_idx: assert property (
    @(posedge CLK) disable iff (!nRST)
    lane_go |-> (!iss.res_wen0 || int'(iss.res_offset) < VLMAX) &&
                (!iss.res_wen1 || int'(iss.res_offset) + 1 < VLMAX)
  );

endmodule

`default_nettype wire

// ==== rtl/vec_execute.sv ====
// decode to execute pipeline register and the two-lane integer ALU
// holds on stall and drops the pair on flush
`default_nettype none

module vec_execute (
  input  logic         CLK,
  input  logic         nRST,
  input  logic         stall,
  input  logic         flush,
  vec_issue_if.execute iss
);

  logic              valid_q;
  logic              wen0_q;
  logic              wen1_q;
  logic              last_q;
  vec_pkg::valu_op_t op_q;
  vec_pkg::src_t     src_q;
  logic [4:0]        vd_q;
  logic [4:0]        offset_q;
  vec_pkg::elem_t    a0_q;
  vec_pkg::elem_t    a1_q;
  vec_pkg::elem_t    b0_q;
  vec_pkg::elem_t    b1_q;
  vec_pkg::elem_t    scalar_q;
  logic [4:0]        imm_q;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      valid_q <= 1'b0;
      wen0_q  <= 1'b0;
      wen1_q  <= 1'b0;
      last_q  <= 1'b0;
    end else if (flush) begin
      valid_q <= 1'b0;
      wen0_q  <= 1'b0;
      wen1_q  <= 1'b0;
      last_q  <= 1'b0;
    end else if (!stall) begin
      valid_q <= iss.valid;
      wen0_q  <= iss.valid && iss.wen0;
      wen1_q  <= iss.valid && iss.wen1;
      last_q  <= iss.valid && iss.last;
    end
  end

  always_ff @(posedge CLK) begin
    if (!stall) begin
      op_q     <= iss.op;
      src_q    <= iss.src;
      vd_q     <= iss.vd;
      offset_q <= iss.offset;
      a0_q     <= iss.a0;
      a1_q     <= iss.a1;
      b0_q     <= iss.b0;
      b1_q     <= iss.b1;
      scalar_q <= iss.scalar;
      imm_q    <= iss.imm;
    end
  end

  // first operand of one lane
  function automatic vec_pkg::elem_t first_op(
    input vec_pkg::src_t  src,
    input vec_pkg::elem_t vs1_elem,
    input vec_pkg::elem_t scalar,
    input logic [4:0]     imm
  );
    case (src)
      vec_pkg::SRC_XS1: first_op = scalar;
      vec_pkg::SRC_IMM: first_op = {{(vec_pkg::ELEN - 5){imm[4]}}, imm};
      default:          first_op = vs1_elem;
    endcase
  endfunction

  // result is vs2 op first operand
  function automatic vec_pkg::elem_t alu(
    input vec_pkg::valu_op_t op,
    input vec_pkg::elem_t    vs2_elem,
    input vec_pkg::elem_t    opnd
  );
    case (op)
      vec_pkg::VALU_SUB: alu = vs2_elem - opnd;
      vec_pkg::VALU_AND: alu = vs2_elem & opnd;
      vec_pkg::VALU_OR:  alu = vs2_elem | opnd;
      vec_pkg::VALU_XOR: alu = vs2_elem ^ opnd;
      default:           alu = vs2_elem + opnd;
    endcase
  endfunction

  assign iss.res0 = alu(op_q, b0_q, first_op(src_q, a0_q, scalar_q, imm_q));
  assign iss.res1 = alu(op_q, b1_q, first_op(src_q, a1_q, scalar_q, imm_q));

  assign iss.res_valid  = valid_q;
  assign iss.res_vd     = vd_q;
  assign iss.res_offset = offset_q;
  assign iss.res_wen0   = wen0_q;
  assign iss.res_wen1   = wen1_q;
  // a flush on the final write edge must not report completion
  assign iss.res_last   = last_q && !flush;

  // decode raises a lane write enable only inside a valid pair
  a_wen_valid: assert property (
    @(posedge CLK) disable iff (!nRST)
    (iss.wen0 || iss.wen1) |-> iss.valid
  );

endmodule

`default_nettype wire

// ==== rtl/vec_decode.sv ====
// OP-V decode, element counter and two-lane operand fetch
// one instruction at a time, pairs go out combinationally to execute
`default_nettype none

module vec_decode #(
  parameter int VLMAX = 8
) (
  input  logic           CLK,
  input  logic           nRST,
  input  logic           instr_valid,
  input  logic [31:0]    instr,
  input  vec_pkg::elem_t xs1,
  input  logic [5:0]     vl,
  input  logic           stall,
  input  logic           flush,
  output logic           busy,
  output logic           illegal,
  vec_rf_if.decode       rf,
  vec_issue_if.decode    iss
);

  // counter is one bit wider than the element index so it can reach VLMAX
  localparam int CW = $clog2(VLMAX) + 1;

  vec_pkg::seq_state_t state_q;
  logic [CW-1:0]       offset_q;
  logic [CW-1:0]       offset_nxt;
  logic [CW-1:0]       idx1;
  logic                last;
  logic                legal;
  logic                f3_ok;
  logic                f6_ok;
  logic                try_start;
  logic                accept;
  logic [5:0]          vl_eff;
  vec_pkg::valu_op_t   op_d;
  vec_pkg::src_t       src_d;

  // latched instruction
  vec_pkg::valu_op_t   op_q;
  vec_pkg::src_t       src_q;
  logic [4:0]          vd_q;
  logic [4:0]          vs1_q;
  logic [4:0]          vs2_q;
  logic                vm_q;
  logic [CW-1:0]       vl_q;
  vec_pkg::elem_t      xs1_q;
  vec_pkg::elem_t      mask_q;

  always_comb begin
    op_d  = vec_pkg::VALU_ADD;
    src_d = vec_pkg::SRC_VS1;
    f6_ok = 1'b1;
    f3_ok = 1'b1;
    case (instr[31:26])
      vec_pkg::F6_VADD: op_d = vec_pkg::VALU_ADD;
      vec_pkg::F6_VSUB: op_d = vec_pkg::VALU_SUB;
      vec_pkg::F6_VAND: op_d = vec_pkg::VALU_AND;
      vec_pkg::F6_VOR:  op_d = vec_pkg::VALU_OR;
      vec_pkg::F6_VXOR: op_d = vec_pkg::VALU_XOR;
      default:          f6_ok = 1'b0;
    endcase
    case (instr[14:12])
      vec_pkg::F3_OPIVV: src_d = vec_pkg::SRC_VS1;
      vec_pkg::F3_OPIVX: src_d = vec_pkg::SRC_XS1;
      vec_pkg::F3_OPIVI: src_d = vec_pkg::SRC_IMM;
      default:           f3_ok = 1'b0;
    endcase
    // there is no vsub.vi, vrsub covers that case
    legal = (instr[6:0] == vec_pkg::OPC_OPV) && f6_ok && f3_ok &&
            !(op_d == vec_pkg::VALU_SUB && src_d == vec_pkg::SRC_IMM);
  end

  // execute still holding a pair counts as busy
  assign busy      = (state_q == vec_pkg::SEQ_RUN) || iss.res_valid;
  assign try_start = instr_valid && !busy;
  assign accept    = try_start && legal;
  assign vl_eff    = (vl > 6'(VLMAX)) ? 6'(VLMAX) : vl;

  assign offset_nxt = offset_q + CW'(2);
  assign idx1       = offset_q + CW'(1);
  // also covers vl of 0, which still runs a single empty pair
  assign last       = offset_nxt >= vl_q;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state_q  <= vec_pkg::SEQ_IDLE;
      offset_q <= '0;
      illegal  <= 1'b0;
    end else begin
      illegal <= try_start && !legal;
      if (flush) begin
        state_q  <= vec_pkg::SEQ_IDLE;
        offset_q <= '0;
      end else begin
        case (state_q)
          vec_pkg::SEQ_IDLE: begin
            if (accept) begin
              state_q  <= vec_pkg::SEQ_RUN;
              offset_q <= '0;
            end
          end
          vec_pkg::SEQ_RUN: begin
            if (!stall) begin
              if (last) begin
                state_q  <= vec_pkg::SEQ_IDLE;
                offset_q <= '0;
              end else begin
                offset_q <= offset_nxt;
              end
            end
          end
          default: state_q <= vec_pkg::SEQ_IDLE;
        endcase
      end
    end
  end

  // v0 is sampled once at acceptance, nothing is in flight then
  always_ff @(posedge CLK) begin
    if (accept) begin
      op_q   <= op_d;
      src_q  <= src_d;
      vd_q   <= instr[11:7];
      vs1_q  <= instr[19:15];
      vs2_q  <= instr[24:20];
      vm_q   <= instr[25];
      vl_q   <= CW'(vl_eff);
      xs1_q  <= xs1;
      mask_q <= rf.mask_word;
    end
  end

  assign rf.vs1    = vs1_q;
  assign rf.vs2    = vs2_q;
  assign rf.offset = 5'(offset_q);

  assign iss.valid  = (state_q == vec_pkg::SEQ_RUN);
  assign iss.op     = op_q;
  assign iss.src    = src_q;
  assign iss.vd     = vd_q;
  assign iss.offset = 5'(offset_q);
  assign iss.a0     = rf.vs1_data0;
  assign iss.a1     = rf.vs1_data1;
  assign iss.b0     = rf.vs2_data0;
  assign iss.b1     = rf.vs2_data1;
  assign iss.scalar = xs1_q;
  assign iss.imm    = vs1_q;
  assign iss.last   = last;

  // tail limit, then the v0 bit when masked
  assign iss.wen0 = iss.valid && (offset_q < vl_q) && (vm_q || mask_q[offset_q]);
  assign iss.wen1 = iss.valid && (idx1 < vl_q) && (vm_q || mask_q[idx1]);

  // clamped vl keeps the lane pair inside the register
  a_offset_range: assert property (
    @(posedge CLK) disable iff (!nRST)
    (state_q == vec_pkg::SEQ_RUN) |-> (offset_q < CW'(VLMAX))
  );

endmodule

`default_nettype wire

// ==== rtl/vec_issue_if.sv ====
// element pair from decode to execute, and lane results from execute to the register file
`default_nettype none

interface vec_issue_if;

  // decoded pair
  logic               valid;
  vec_pkg::valu_op_t  op;
  vec_pkg::src_t      src;
  logic [4:0]         vd;
  logic [4:0]         offset;
  vec_pkg::elem_t     a0;
  vec_pkg::elem_t     a1;
  vec_pkg::elem_t     b0;
  vec_pkg::elem_t     b1;
  logic               wen0;
  logic               wen1;
  vec_pkg::elem_t     scalar;
  logic [4:0]         imm;
  logic               last;

  // lane results
  logic               res_valid;
  logic [4:0]         res_vd;
  logic [4:0]         res_offset;
  vec_pkg::elem_t     res0;
  vec_pkg::elem_t     res1;
  logic               res_wen0;
  logic               res_wen1;
  logic               res_last;

  // decode watches res_valid to keep busy up until the final write
  modport decode (
    output valid, op, src, vd, offset, a0, a1, b0, b1, wen0, wen1, scalar, imm, last,
    input  res_valid
  );

  modport execute (
    input  valid, op, src, vd, offset, a0, a1, b0, b1, wen0, wen1, scalar, imm, last,
    output res_valid, res_vd, res_offset, res0, res1, res_wen0, res_wen1, res_last
  );

  modport result (
    input  res_valid, res_vd, res_offset, res0, res1, res_wen0, res_wen1, res_last
  );

endinterface

`default_nettype wire

// ==== rtl/vec_rf_if.sv ====
// register file read port used by decode, two lanes of vs1 and vs2 plus the v0 word
`default_nettype none

interface vec_rf_if;

  logic [4:0]     vs1;
  logic [4:0]     vs2;
  // lane 0 index, lane 1 reads offset + 1
  logic [4:0]     offset;
  vec_pkg::elem_t vs1_data0;
  vec_pkg::elem_t vs1_data1;
  vec_pkg::elem_t vs2_data0;
  vec_pkg::elem_t vs2_data1;
  vec_pkg::elem_t mask_word;

  modport decode (
    output vs1, vs2, offset,
    input  vs1_data0, vs1_data1, vs2_data0, vs2_data1, mask_word
  );

  modport regfile (
    input  vs1, vs2, offset,
    output vs1_data0, vs1_data1, vs2_data0, vs2_data1, mask_word
  );

endinterface

`default_nettype wire

// ==== rtl/vec_pkg.sv ====
// shared types and encodings for the two-lane vector integer unit
// referenced by scoped name from the rtl files
`default_nettype none

package vec_pkg;

  // element width, fixed at 32 bits
  parameter int ELEN = 32;

  // register count, set by the 5-bit register fields
  parameter int NREG = 32;

  // major opcode for OP-V
  parameter logic [6:0] OPC_OPV = 7'b1010111;

  // funct3 operand forms
  parameter logic [2:0] F3_OPIVV = 3'b000;
  parameter logic [2:0] F3_OPIVX = 3'b100;
  parameter logic [2:0] F3_OPIVI = 3'b011;

  // funct6 codes of the supported integer ops
  parameter logic [5:0] F6_VADD = 6'b000000;
  parameter logic [5:0] F6_VSUB = 6'b000010;
  parameter logic [5:0] F6_VAND = 6'b001001;
  parameter logic [5:0] F6_VOR  = 6'b001010;
  parameter logic [5:0] F6_VXOR = 6'b001011;

  typedef enum logic [2:0] {
    VALU_ADD,
    VALU_SUB,
    VALU_AND,
    VALU_OR,
    VALU_XOR
  } valu_op_t;

  // where the first operand of each lane comes from
  typedef enum logic [1:0] {
    SRC_VS1,
    SRC_XS1,
    SRC_IMM
  } src_t;

  typedef enum logic {
    SEQ_IDLE,
    SEQ_RUN
  } seq_state_t;

  typedef logic [ELEN-1:0] elem_t;

endpackage

`default_nettype wire
